// File: src/csr_pkg.sv
`default_nettype none

package csr_pkg;

  ////////////////////////////////////////////////////////////
  // basic csr types
  ////////////////////////////////////////////////////////////

  // one csr data word
  typedef logic [31:0] csr_word_t;
  // 12 bit csr address space
  typedef logic [11:0] csr_addr_t;

  // csr instruction op, as decoded by the core
  typedef enum logic [1:0] {
    CSR_OP_NONE  = 2'b00,
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_op_e;

  // stored cause: bit 5 irq flag, bits 4..0 code
  typedef logic [5:0] mcause_t;

  ////////////////////////////////////////////////////////////
  // performance counters
  ////////////////////////////////////////////////////////////

  localparam int unsigned N_PERF_CNT = 8;

  // one bit per counter
  typedef logic [N_PERF_CNT-1:0] perf_evt_t;

  // saturation point
  localparam csr_word_t PERF_CNT_MAX = '1;
  // global enable and saturate both on
  localparam logic [1:0] PCMR_RESET = 2'b11;

  ////////////////////////////////////////////////////////////
  // csr map
  ////////////////////////////////////////////////////////////

  localparam csr_addr_t CSR_MSTATUS   = 12'h300;
  localparam csr_addr_t CSR_MTVEC     = 12'h305;
  localparam csr_addr_t CSR_MEPC      = 12'h341;
  localparam csr_addr_t CSR_MCAUSE    = 12'h342;
  localparam csr_addr_t CSR_MHARTID   = 12'hF14;
  // counters live at 0x780..0x79F
  localparam csr_addr_t CSR_PCCR_BASE = 12'h780;
  localparam csr_addr_t CSR_PCER      = 12'h7A0;
  localparam csr_addr_t CSR_PCMR      = 12'h7A1;

  // mstatus field positions
  localparam int unsigned MSTATUS_MIE_BIT  = 3;
  localparam int unsigned MSTATUS_MPIE_BIT = 7;
  localparam int unsigned MSTATUS_MPP_LSB  = 11;

endpackage

`default_nettype wire

// File: src/csr_bus_if.sv
`timescale 1ns/100ps
`default_nettype none

// internal csr bus between access controller and the two register peers
interface csr_bus_if
  import csr_pkg::*;
();

  // controller side
  logic      wr_en;
  logic      sel_mach;
  logic      sel_perf;
  csr_addr_t addr;
  csr_word_t wr_value;

  // each peer returns its own read data, zero on unknown address
  csr_word_t rdata_mach;
  csr_word_t rdata_perf;

  modport ctrl (
    output wr_en, sel_mach, sel_perf, addr, wr_value,
    input  rdata_mach, rdata_perf
  );

  modport mach (
    input  wr_en, sel_mach, addr, wr_value,
    output rdata_mach
  );

  modport perf (
    input  wr_en, sel_perf, addr, wr_value,
    output rdata_perf
  );

endinterface

`default_nettype wire

// File: src/csr_access_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module csr_access_ctrl
  import csr_pkg::*;
(
  input  logic      csr_access_i,
  input  csr_addr_t csr_addr_i,
  input  csr_word_t csr_wdata_i,
  input  csr_op_e   csr_op_i,
  output csr_word_t csr_rdata_o,
  csr_bus_if.ctrl   bus
);

  logic      is_mach;
  logic      is_perf;
  csr_word_t sel_rdata;

  ////////////////////////////////////////////////////////////
  // address decode
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (csr_addr_i)
      CSR_MSTATUS, CSR_MTVEC, CSR_MEPC, CSR_MCAUSE, CSR_MHARTID: is_mach = 1'b1;
      default: is_mach = 1'b0;
    endcase
  end

  // counter window plus the two control regs
  assign is_perf = (csr_addr_i[11:5] == CSR_PCCR_BASE[11:5]) ||
                   (csr_addr_i == CSR_PCER) ||
                   (csr_addr_i == CSR_PCMR);

  assign bus.addr     = csr_addr_i;
  assign bus.sel_mach = is_mach;
  assign bus.sel_perf = is_perf;

  ////////////////////////////////////////////////////////////
  // read merge and write value
  ////////////////////////////////////////////////////////////

  // at most one peer is selected
  assign sel_rdata = is_mach ? bus.rdata_mach :
                     is_perf ? bus.rdata_perf : '0;

  // no access, no read data
  assign csr_rdata_o = csr_access_i ? sel_rdata : '0;

  // read-modify-write uses the old value of the selected register
  always_comb begin
    case (csr_op_i)
      CSR_OP_WRITE: bus.wr_value = csr_wdata_i;
      CSR_OP_SET:   bus.wr_value = sel_rdata | csr_wdata_i;
      CSR_OP_CLEAR: bus.wr_value = sel_rdata & ~csr_wdata_i;
      default:      bus.wr_value = csr_wdata_i;
    endcase
  end

  // none op is a pure read
  assign bus.wr_en = csr_access_i && (csr_op_i != CSR_OP_NONE);

endmodule

`default_nettype wire

// File: src/csr_machine_regs.sv
`timescale 1ns/100ps
`default_nettype none

module csr_machine_regs
  import csr_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  csr_bus_if.mach   bus,
  input  logic [3:0]  core_id_i,
  input  logic [5:0]  cluster_id_i,
  input  logic [23:0] boot_addr_i,
  input  logic      csr_save_cause_i,
  input  logic      csr_save_if_i,
  input  logic      csr_save_id_i,
  input  logic      csr_restore_mret_i,
  input  mcause_t   csr_cause_i,
  input  csr_word_t pc_if_i,
  input  csr_word_t pc_id_i,
  output csr_word_t epc_o,
  output logic      m_irq_enable_o
);

  logic      mie_q, mie_n;
  logic      mpie_q, mpie_n;
  csr_word_t mepc_q, mepc_n;
  mcause_t   mcause_q, mcause_n;
  csr_word_t exc_pc;
  logic      mach_we;

  ////////////////////////////////////////////////////////////
  // read side
  ////////////////////////////////////////////////////////////

  always_comb begin
    bus.rdata_mach = '0;
    case (bus.addr)
      CSR_MSTATUS: begin
        bus.rdata_mach[MSTATUS_MIE_BIT]        = mie_q;
        bus.rdata_mach[MSTATUS_MPIE_BIT]       = mpie_q;
        // mpp tied to machine mode
        bus.rdata_mach[MSTATUS_MPP_LSB +: 2]   = 2'b11;
      end
      // trap base from boot address, 256 byte aligned
      CSR_MTVEC:   bus.rdata_mach = {boot_addr_i, 8'h00};
      CSR_MEPC:    bus.rdata_mach = mepc_q;
      // irq flag moves up to bit 31
      CSR_MCAUSE:  bus.rdata_mach = {mcause_q[5], 26'b0, mcause_q[4:0]};
      CSR_MHARTID: bus.rdata_mach = {21'b0, cluster_id_i, 1'b0, core_id_i};
      default: ;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // next state
  ////////////////////////////////////////////////////////////

  assign mach_we = bus.wr_en && bus.sel_mach;

  // id stage pc unless the fetch stage asks for its own
  always_comb begin
    exc_pc = pc_id_i;
    if (csr_save_if_i) begin
      exc_pc = pc_if_i;
    end else if (csr_save_id_i) begin
      exc_pc = pc_id_i;
    end
  end

  always_comb begin
    mie_n    = mie_q;
    mpie_n   = mpie_q;
    mepc_n   = mepc_q;
    mcause_n = mcause_q;

    // csr instruction writes first
    if (mach_we) begin
      case (bus.addr)
        CSR_MSTATUS: begin
          mie_n  = bus.wr_value[MSTATUS_MIE_BIT];
          mpie_n = bus.wr_value[MSTATUS_MPIE_BIT];
        end
        CSR_MEPC:   mepc_n   = bus.wr_value;
        CSR_MCAUSE: mcause_n = {bus.wr_value[31], bus.wr_value[4:0]};
        default: ;
      endcase
    end

    // trap events override only the fields they touch
    if (csr_save_cause_i) begin
      mpie_n   = mie_q;
      mie_n    = 1'b0;
      mepc_n   = exc_pc;
      mcause_n = csr_cause_i;
    end else if (csr_restore_mret_i) begin
      mie_n  = mpie_q;
      mpie_n = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mie_q    <= 1'b0;
      mpie_q   <= 1'b0;
      mepc_q   <= '0;
      mcause_q <= '0;
    end else begin
      mie_q    <= mie_n;
      mpie_q   <= mpie_n;
      mepc_q   <= mepc_n;
      mcause_q <= mcause_n;
    end
  end

  assign epc_o          = mepc_q;
  assign m_irq_enable_o = mie_q;

endmodule

`default_nettype wire

// File: src/csr_perf_counters.sv
`timescale 1ns/100ps
`default_nettype none

module csr_perf_counters
  import csr_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  csr_bus_if.perf bus,
  input  logic    id_valid_i,
  input  logic    is_decoding_i,
  input  logic    ld_stall_i,
  input  logic    jump_i,
  input  logic    branch_i,
  input  logic    branch_taken_i,
  input  logic    mem_load_i,
  input  logic    mem_store_i
);

  logic       id_valid_q;
  perf_evt_t  evt;
  perf_evt_t  inc;
  perf_evt_t  inc_q;
  perf_evt_t  pcer_q;
  logic [1:0] pcmr_q;
  csr_word_t  cnt_q [N_PERF_CNT];
  csr_word_t  cnt_n [N_PERF_CNT];
  logic       perf_we;
  logic       is_pccr;
  logic [4:0] pccr_idx;

  ////////////////////////////////////////////////////////////
  // event sources
  ////////////////////////////////////////////////////////////

  assign evt[0] = 1'b1;
  assign evt[1] = id_valid_i & is_decoding_i;
  // hazards and control flow qualified by last cycle's id_valid
  assign evt[2] = ld_stall_i & id_valid_q;
  assign evt[3] = jump_i & id_valid_q;
  assign evt[4] = branch_i & id_valid_q;
  assign evt[5] = branch_i & branch_taken_i & id_valid_q;
  assign evt[6] = mem_load_i;
  assign evt[7] = mem_store_i;

  // per-counter enable and global enable
  assign inc = evt & pcer_q & {N_PERF_CNT{pcmr_q[0]}};

  ////////////////////////////////////////////////////////////
  // csr decode and read
  ////////////////////////////////////////////////////////////

  assign perf_we  = bus.wr_en && bus.sel_perf;
  assign is_pccr  = (bus.addr[11:5] == CSR_PCCR_BASE[11:5]);
  assign pccr_idx = bus.addr[4:0];

  always_comb begin
    bus.rdata_perf = '0;
    if (bus.addr == CSR_PCER) begin
      bus.rdata_perf = csr_word_t'(pcer_q);
    end else if (bus.addr == CSR_PCMR) begin
      bus.rdata_perf = csr_word_t'(pcmr_q);
    end else if (is_pccr) begin
      // indices past the last counter stay zero
      for (int i = 0; i < N_PERF_CNT; i++) begin
        if (pccr_idx == 5'(i)) bus.rdata_perf = cnt_q[i];
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // counter update
  ////////////////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < N_PERF_CNT; i++) begin
      cnt_n[i] = cnt_q[i];
      // hold at max only when saturating
      if (inc_q[i] && !((cnt_q[i] == PERF_CNT_MAX) && pcmr_q[1])) begin
        cnt_n[i] = cnt_q[i] + 32'd1;
      end
      // csr write wins over this edge's increment
      if (perf_we && is_pccr && (pccr_idx == 5'(i))) begin
        cnt_n[i] = bus.wr_value;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_valid_q <= 1'b0;
      inc_q      <= '0;
      pcer_q     <= '0;
      pcmr_q     <= PCMR_RESET;
      for (int i = 0; i < N_PERF_CNT; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      id_valid_q <= id_valid_i;
      inc_q      <= inc;
      if (perf_we && (bus.addr == CSR_PCER)) pcer_q <= bus.wr_value[N_PERF_CNT-1:0];
      if (perf_we && (bus.addr == CSR_PCMR)) pcmr_q <= bus.wr_value[1:0];
      for (int i = 0; i < N_PERF_CNT; i++) begin
        cnt_q[i] <= cnt_n[i];
      end
    end
  end

endmodule

`default_nettype wire

// File: src/csr_top.sv
`timescale 1ns/100ps
`default_nettype none

module csr_top
  import csr_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  // hart identity and boot
  input  logic [3:0]  core_id_i,
  input  logic [5:0]  cluster_id_i,
  input  logic [23:0] boot_addr_i,
  // csr instruction port
  input  logic        csr_access_i,
  input  csr_addr_t   csr_addr_i,
  input  csr_word_t   csr_wdata_i,
  input  csr_op_e     csr_op_i,
  output csr_word_t   csr_rdata_o,
  // trap control from the core controller
  input  logic        csr_save_cause_i,
  input  logic        csr_save_if_i,
  input  logic        csr_save_id_i,
  input  logic        csr_restore_mret_i,
  input  mcause_t     csr_cause_i,
  input  csr_word_t   pc_if_i,
  input  csr_word_t   pc_id_i,
  output csr_word_t   epc_o,
  output logic        m_irq_enable_o,
  // counter events
  input  logic        id_valid_i,
  input  logic        is_decoding_i,
  input  logic        ld_stall_i,
  input  logic        jump_i,
  input  logic        branch_i,
  input  logic        branch_taken_i,
  input  logic        mem_load_i,
  input  logic        mem_store_i
);

  csr_bus_if u_bus ();

  csr_access_ctrl u_ctrl (
    .csr_access_i (csr_access_i),
    .csr_addr_i   (csr_addr_i),
    .csr_wdata_i  (csr_wdata_i),
    .csr_op_i     (csr_op_i),
    .csr_rdata_o  (csr_rdata_o),
    .bus          (u_bus.ctrl)
  );

  csr_machine_regs u_mach (
    .clk                (clk),
    .rst_n              (rst_n),
    .bus                (u_bus.mach),
    .core_id_i          (core_id_i),
    .cluster_id_i       (cluster_id_i),
    .boot_addr_i        (boot_addr_i),
    .csr_save_cause_i   (csr_save_cause_i),
    .csr_save_if_i      (csr_save_if_i),
    .csr_save_id_i      (csr_save_id_i),
    .csr_restore_mret_i (csr_restore_mret_i),
    .csr_cause_i        (csr_cause_i),
    .pc_if_i            (pc_if_i),
    .pc_id_i            (pc_id_i),
    .epc_o              (epc_o),
    .m_irq_enable_o     (m_irq_enable_o)
  );

  csr_perf_counters u_perf (
    .clk            (clk),
    .rst_n          (rst_n),
    .bus            (u_bus.perf),
    .id_valid_i     (id_valid_i),
    .is_decoding_i  (is_decoding_i),
    .ld_stall_i     (ld_stall_i),
    .jump_i         (jump_i),
    .branch_i       (branch_i),
    .branch_taken_i (branch_taken_i),
    .mem_load_i     (mem_load_i),
    .mem_store_i    (mem_store_i)
  );

endmodule

`default_nettype wire

// File: verification/csr_asserts.sv
`timescale 1ns/100ps
`default_nettype none

module csr_asserts
  import csr_pkg::*;
(
  input logic      clk,
  input logic      rst_n,
  input logic      csr_access_i,
  input csr_word_t csr_rdata_o,
  input logic      csr_save_cause_i,
  input logic      csr_save_if_i,
  input csr_word_t pc_if_i,
  input csr_word_t pc_id_i,
  input csr_word_t epc_o,
  input logic      m_irq_enable_o
);

  // trap entry masks interrupts
  mie_clear_on_save: assert property (
    @(posedge clk) disable iff (!rst_n) csr_save_cause_i |=> !m_irq_enable_o
  ) else $error("m_irq_enable_o still high after a trap save");

  // saved pc follows the save_if select
  epc_after_save: assert property (
    @(posedge clk) disable iff (!rst_n)
      csr_save_cause_i |=> (epc_o == $past(csr_save_if_i ? pc_if_i : pc_id_i))
  ) else $error("epc_o does not hold the pc sampled at the trap save");

  // idle port returns zero
  rdata_zero_idle: assert property (
    @(posedge clk) disable iff (!rst_n) !csr_access_i |-> (csr_rdata_o == '0)
  ) else $error("csr_rdata_o nonzero without an access");

endmodule

`default_nettype wire

// File: verification/tb_csr_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_csr_top
  import csr_pkg::*;
();

  // one table row: csr access, trap controls, expected readback
  typedef struct {
    csr_op_e   op;
    csr_addr_t addr;
    csr_word_t wdata;
    logic [3:0] trap;
    mcause_t   cause;
    csr_word_t exp_rdata;
    logic      exp_mie;
  } step_t;

  logic        clk;
  logic        rst_n;
  logic [3:0]  core_id_i;
  logic [5:0]  cluster_id_i;
  logic [23:0] boot_addr_i;
  logic        csr_access_i;
  csr_addr_t   csr_addr_i;
  csr_word_t   csr_wdata_i;
  csr_op_e     csr_op_i;
  csr_word_t   csr_rdata_o;
  logic        csr_save_cause_i;
  logic        csr_save_if_i;
  logic        csr_save_id_i;
  logic        csr_restore_mret_i;
  mcause_t     csr_cause_i;
  csr_word_t   pc_if_i;
  csr_word_t   pc_id_i;
  csr_word_t   epc_o;
  logic        m_irq_enable_o;
  logic        id_valid_i;
  logic        is_decoding_i;
  logic        ld_stall_i;
  logic        jump_i;
  logic        branch_i;
  logic        branch_taken_i;
  logic        mem_load_i;
  logic        mem_store_i;

  step_t     steps[$];
  int        errors;
  int        checks;
  int        cycles = 0;
  int        seed;
  csr_word_t mepc_model;

  csr_top dut (.*);

  bind csr_top csr_asserts u_asserts (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // compare tasks and reference op rule
  ////////////////////////////////////////////////////////////

  task automatic check_word(input string name, input csr_word_t got, input csr_word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s = 0x%08h, expected 0x%08h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s = 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  // write / set / clear as seen by software
  function automatic csr_word_t apply_op(csr_op_e op, csr_word_t old, csr_word_t wdata);
    case (op)
      CSR_OP_WRITE: return wdata;
      CSR_OP_SET:   return old | wdata;
      CSR_OP_CLEAR: return old & ~wdata;
      default:      return old;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////
  // stimulus table
  ////////////////////////////////////////////////////////////

  // trap field order: save_cause, save_if, save_id, mret
  task automatic add_step(input csr_op_e op, input csr_addr_t addr, input csr_word_t wdata,
                          input logic [3:0] trap, input mcause_t cause,
                          input csr_word_t exp_rdata, input logic exp_mie);
    step_t s;
    s.op        = op;
    s.addr      = addr;
    s.wdata     = wdata;
    s.trap      = trap;
    s.cause     = cause;
    s.exp_rdata = exp_rdata;
    s.exp_mie   = exp_mie;
    steps.push_back(s);
  endtask

  task automatic build_table();
    csr_op_e   mepc_ops[4];
    csr_word_t rnd;
    mepc_ops = '{CSR_OP_WRITE, CSR_OP_SET, CSR_OP_CLEAR, CSR_OP_NONE};
    // reset state, mpp reads as machine
    add_step(CSR_OP_NONE, CSR_MSTATUS, 32'h0, 4'b0000, 6'h00, 32'h0000_1800, 1'b0);
    // mepc through every op with random data
    for (int i = 0; i < 8; i++) begin
      rnd = $random(seed);
      mepc_model = apply_op(mepc_ops[i % 4], mepc_model, rnd);
      add_step(mepc_ops[i % 4], CSR_MEPC, rnd, 4'b0000, 6'h00, mepc_model, 1'b0);
    end
    add_step(CSR_OP_WRITE, CSR_MSTATUS, 32'hFFFF_FFFF, 4'b0000, 6'h00, 32'h0000_1888, 1'b1);
    // read only regs ignore the write
    add_step(CSR_OP_WRITE, CSR_MTVEC, 32'hFFFF_FFFF, 4'b0000, 6'h00, 32'h1C00_8000, 1'b1);
    // cluster 0x2a at bit 5, core 5
    add_step(CSR_OP_NONE, CSR_MHARTID, 32'h0, 4'b0000, 6'h00, 32'h0000_0545, 1'b1);
    add_step(CSR_OP_NONE, 12'h123, 32'h0, 4'b0000, 6'h00, 32'h0, 1'b1);
    // trap from IF beats the mstatus write, mpie keeps old mie
    add_step(CSR_OP_WRITE, CSR_MSTATUS, 32'h0, 4'b1100, 6'h2B, 32'h0000_1880, 1'b0);
    add_step(CSR_OP_NONE, CSR_MEPC, 32'h0, 4'b0000, 6'h00, pc_if_i, 1'b0);
    add_step(CSR_OP_NONE, CSR_MCAUSE, 32'h0, 4'b0000, 6'h00, 32'h8000_000B, 1'b0);
    add_step(CSR_OP_NONE, CSR_MSTATUS, 32'h0, 4'b0001, 6'h00, 32'h0000_1888, 1'b1);
    // second trap, ID stage pc
    add_step(CSR_OP_NONE, CSR_MEPC, 32'h0, 4'b1010, 6'h05, pc_id_i, 1'b0);
    add_step(CSR_OP_NONE, CSR_MCAUSE, 32'h0, 4'b0000, 6'h00, 32'h0000_0005, 1'b0);
    add_step(CSR_OP_NONE, CSR_MSTATUS, 32'h0, 4'b0001, 6'h00, 32'h0000_1888, 1'b1);
  endtask

  // drive one row, then read the same address back
  task automatic run_step(input step_t s);
    @(posedge clk);
    csr_access_i       <= 1'b1;
    csr_op_i           <= s.op;
    csr_addr_i         <= s.addr;
    csr_wdata_i        <= s.wdata;
    csr_save_cause_i   <= s.trap[3];
    csr_save_if_i      <= s.trap[2];
    csr_save_id_i      <= s.trap[1];
    csr_restore_mret_i <= s.trap[0];
    csr_cause_i        <= s.cause;
    @(posedge clk);
    csr_op_i           <= CSR_OP_NONE;
    csr_save_cause_i   <= 1'b0;
    csr_save_if_i      <= 1'b0;
    csr_save_id_i      <= 1'b0;
    csr_restore_mret_i <= 1'b0;
    @(negedge clk);
    check_word("csr_rdata_o", csr_rdata_o, s.exp_rdata);
    check_bit("m_irq_enable_o", m_irq_enable_o, s.exp_mie);
  endtask

  ////////////////////////////////////////////////////////////
  // counter helpers
  ////////////////////////////////////////////////////////////

  task automatic csr_write(input csr_addr_t addr, input csr_word_t data);
    @(posedge clk);
    csr_access_i <= 1'b1;
    csr_op_i     <= CSR_OP_WRITE;
    csr_addr_i   <= addr;
    csr_wdata_i  <= data;
    @(posedge clk);
    csr_op_i     <= CSR_OP_NONE;
  endtask

  task automatic csr_read_check(input csr_addr_t addr, input csr_word_t exp);
    @(posedge clk);
    csr_access_i <= 1'b1;
    csr_op_i     <= CSR_OP_NONE;
    csr_addr_i   <= addr;
    @(negedge clk);
    check_word("csr_rdata_o", csr_rdata_o, exp);
  endtask

  // n cycles of loads, then let the pipeline drain
  task automatic pulse_load(input int n);
    repeat (n) begin
      @(posedge clk);
      mem_load_i <= 1'b1;
    end
    @(posedge clk);
    mem_load_i <= 1'b0;
    repeat (2) @(posedge clk);
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    rst_n              = 1'b0;
    core_id_i          = 4'h5;
    cluster_id_i       = 6'h2A;
    boot_addr_i        = 24'h1C_0080;
    csr_access_i       = 1'b0;
    csr_addr_i         = '0;
    csr_wdata_i        = '0;
    csr_op_i           = CSR_OP_NONE;
    csr_save_cause_i   = 1'b0;
    csr_save_if_i      = 1'b0;
    csr_save_id_i      = 1'b0;
    csr_restore_mret_i = 1'b0;
    csr_cause_i        = '0;
    pc_if_i            = 32'h0000_1A40;
    pc_id_i            = 32'h0000_1A3C;
    id_valid_i         = 1'b0;
    is_decoding_i      = 1'b0;
    ld_stall_i         = 1'b0;
    jump_i             = 1'b0;
    branch_i           = 1'b0;
    branch_taken_i     = 1'b0;
    mem_load_i         = 1'b0;
    mem_store_i        = 1'b0;
    errors             = 0;
    checks             = 0;
    seed               = 32'hdcbd;
    mepc_model         = '0;
    build_table();

    repeat (10) @(posedge clk);
    rst_n <= 1'b1;

    foreach (steps[i]) begin
      run_step(steps[i]);
    end
    // last trap came from the ID stage
    check_word("epc_o", epc_o, pc_id_i);

    // idle port reads zero on a live address
    @(posedge clk);
    csr_access_i <= 1'b0;
    csr_addr_i   <= CSR_MSTATUS;
    @(negedge clk);
    check_word("csr_rdata_o", csr_rdata_o, 32'h0);

    // load counter, index 6
    csr_write(CSR_PCCR_BASE + 12'd6, 32'h0000_0100);
    csr_write(CSR_PCER, 32'h0000_0040);
    pulse_load(5);
    csr_read_check(CSR_PCCR_BASE + 12'd6, 32'h0000_0105);
    // global enable off, count frozen
    csr_write(CSR_PCMR, 32'h0000_0002);
    pulse_load(5);
    csr_read_check(CSR_PCCR_BASE + 12'd6, 32'h0000_0105);

    // cycle counter close to the top
    csr_write(CSR_PCCR_BASE, 32'hFFFF_FFFD);
    csr_write(CSR_PCMR, 32'hFFFF_FFFF);
    csr_write(CSR_PCER, 32'hFFFF_FFFF);
    csr_read_check(CSR_PCMR, 32'h0000_0003);
    csr_read_check(CSR_PCER, 32'h0000_00FF);
    repeat (4) @(posedge clk);
    csr_read_check(CSR_PCCR_BASE, 32'hFFFF_FFFF);

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // watchdog sized from the table plus the counter tests
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= steps.size() * 4 + 200) begin
      $display("timeout: run did not finish within %0d cycles", cycles);
      $display("Simulation failed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: vlog.f
src/csr_pkg.sv
src/csr_bus_if.sv
src/csr_access_ctrl.sv
src/csr_machine_regs.sv
src/csr_perf_counters.sv
src/csr_top.sv
verification/csr_asserts.sv
verification/tb_csr_top.sv

// File: Makefile
SIM  = obj_dir/Vtb_csr_top
SRCS = $(shell cat vlog.f)

.PHONY: run clean

run: $(SIM)
	./$(SIM) > sim.log 2>&1 || echo "Simulation failed" >> sim.log
	cat sim.log
	! grep -q "Simulation failed" sim.log

$(SIM): vlog.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_csr_top -f vlog.f

clean:
	rm -rf obj_dir sim.log
